/* rtl/mm_params.svh */
`ifndef MM_PARAMS_SVH
`define MM_PARAMS_SVH

// matrix dimension
// also the number of outer-product steps in matrix mode
`define MM_N 4

// width of one input element
`define MM_W 16

// width of one unsigned product
`define MM_PROD_W (2 * `MM_W)

// accumulator width
// a sum of MM_N full products never overflows this
`define MM_ACC_W (`MM_PROD_W + $clog2(`MM_N))

// step counter width, covers 0 to MM_N-1
`define MM_CNT_W ($clog2(`MM_N))

`endif

/* rtl/mm_pkg.sv */
`include "mm_params.svh"

package mm_pkg;

	// one input element
	typedef logic [`MM_W-1:0] elem_t;

	// one product of two elements
	typedef logic [`MM_PROD_W-1:0] prod_t;

	// one result cell
	typedef logic [`MM_ACC_W-1:0] acc_t;

	// matrices are indexed [row][col]
	typedef elem_t [`MM_N-1:0][`MM_N-1:0] elem_mat_t;
	typedef prod_t [`MM_N-1:0][`MM_N-1:0] prod_mat_t;
	typedef acc_t [`MM_N-1:0][`MM_N-1:0] acc_mat_t;

	// operating mode, driven as a level
	typedef enum logic {
		MODE_ELEM = 1'b0, // cell-by-cell products
		MODE_MAT = 1'b1 // full A times B over MM_N steps
	} mode_t;

endpackage

/* rtl/operand_sched.sv */
`timescale 1ns/1ns
`include "mm_params.svh"

module operand_sched import mm_pkg::*; (
	input logic i,
	input logic arst_n,
	input logic en,
	input mode_t mat_mode,
	input elem_mat_t a,
	input elem_mat_t b,
	output elem_mat_t op_a,
	output elem_mat_t op_b,
	output logic op_valid,
	output logic op_first,
	output logic op_last
);

	localparam int CNT_W = `MM_CNT_W;
	localparam int LAST_STEP = `MM_N - 1;

	logic [CNT_W-1:0] step; // current outer-product step
	logic step_first;
	logic step_last;
	elem_mat_t bcast_a; // column step of a along each row
	elem_mat_t bcast_b; // row step of b down each column
	elem_mat_t nxt_a;
	elem_mat_t nxt_b;
	logic nxt_first;
	logic nxt_last;

	assign step_first = (step == '0);
	assign step_last = (step == CNT_W'(LAST_STEP));

	// step counter, only moves in matrix mode
	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			step <= '0;
		end else if (mat_mode == MODE_ELEM) begin
			step <= '0; // abandons any partial sequence
		end else if (en) begin
			if (step_last) begin
				step <= '0;
			end else begin
				step <= step + 1'b1;
			end
		end
	end

	// broadcast of the current column of a and row of b
	always_comb begin
		for (int r = 0; r < `MM_N; r++) begin
			for (int c = 0; c < `MM_N; c++) begin
				bcast_a[r][c] = a[r][step];
				bcast_b[r][c] = b[step][c];
			end
		end
	end

	// select operands and tags for this cycle
	always_comb begin
		if (mat_mode == MODE_MAT) begin
			nxt_a = bcast_a;
			nxt_b = bcast_b;
			nxt_first = step_first;
			nxt_last = step_last;
		end else begin
			nxt_a = a; // pass-through
			nxt_b = b;
			nxt_first = 1'b1; // every item is a whole result
			nxt_last = 1'b1;
		end
	end

	// operand registers, loaded only when an item enters
	always_ff @(posedge i) begin
		if (en) begin
			op_a <= nxt_a;
			op_b <= nxt_b;
		end
	end

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			op_valid <= 1'b0;
			op_first <= 1'b0;
			op_last <= 1'b0;
		end else begin
			op_valid <= en;
			op_first <= nxt_first;
			op_last <= nxt_last;
		end
	end

endmodule

/* rtl/mult_array.sv */
`timescale 1ns/1ns
`include "mm_params.svh"

module mult_array import mm_pkg::*; (
	input logic i,
	input logic arst_n,
	input elem_mat_t op_a,
	input elem_mat_t op_b,
	input logic op_valid,
	input logic op_first,
	input logic op_last,
	output prod_mat_t prod,
	output logic prod_valid,
	output logic prod_first,
	output logic prod_last
);

	prod_mat_t mul; // unregistered products

	// one unsigned multiplier per cell, each with its own output register
	for (genvar r = 0; r < `MM_N; r++) begin : g_row
		for (genvar c = 0; c < `MM_N; c++) begin : g_col
			// widen before multiplying so no high bits are lost
			assign mul[r][c] = prod_t'(op_a[r][c]) * prod_t'(op_b[r][c]);

			always_ff @(posedge i) begin
				if (op_valid) begin
					prod[r][c] <= mul[r][c];
				end
			end
		end
	end

	// tags travel with the products
	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			prod_valid <= 1'b0;
			prod_first <= 1'b0;
			prod_last <= 1'b0;
		end else begin
			prod_valid <= op_valid;
			prod_first <= op_first;
			prod_last <= op_last;
		end
	end

endmodule

/* rtl/result_accum.sv */
`timescale 1ns/1ns
`include "mm_params.svh"

module result_accum import mm_pkg::*; (
	input logic i,
	input logic arst_n,
	input prod_mat_t prod,
	input logic prod_valid,
	input logic prod_first,
	input logic prod_last,
	output acc_mat_t result,
	output logic done
);

	acc_mat_t prod_ext; // products widened to the accumulator
	acc_mat_t sum; // running value plus the new product
	acc_mat_t nxt_result;

	for (genvar r = 0; r < `MM_N; r++) begin : g_row
		for (genvar c = 0; c < `MM_N; c++) begin : g_col
			assign prod_ext[r][c] = acc_t'(prod[r][c]); // zero extend
			assign sum[r][c] = result[r][c] + prod_ext[r][c];

			// first item starts a new sum, the rest add on
			always_comb begin
				if (prod_first) begin
					nxt_result[r][c] = prod_ext[r][c];
				end else begin
					nxt_result[r][c] = sum[r][c];
				end
			end

			// result holds between valid items
			always_ff @(posedge i or negedge arst_n) begin
				if (!arst_n) begin
					result[r][c] <= '0;
				end else if (prod_valid) begin
					result[r][c] <= nxt_result[r][c];
				end
			end
		end
	end

	// done marks the cycle in which a finished result is visible
	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			done <= 1'b0;
		end else begin
			done <= prod_valid && prod_last;
		end
	end

endmodule

/* rtl/mat_mult.sv */
`timescale 1ns/1ns
`include "mm_params.svh"

module mat_mult import mm_pkg::*; (
	input logic i,
	input logic arst_n,
	input logic en,
	input mode_t mat_mode,
	input elem_mat_t a,
	input elem_mat_t b,
	output acc_mat_t result,
	output logic done
);

	// stage 1 to stage 2
	elem_mat_t op_a;
	elem_mat_t op_b;
	logic op_valid;
	logic op_first;
	logic op_last;

	// stage 2 to stage 3
	prod_mat_t prod;
	logic prod_valid;
	logic prod_first;
	logic prod_last;

	// stage 1
	// the only place where mode and step count are seen
	operand_sched operand_sched_inst (
		.i(i),
		.arst_n(arst_n),
		.en(en),
		.mat_mode(mat_mode),
		.a(a),
		.b(b),
		.op_a(op_a),
		.op_b(op_b),
		.op_valid(op_valid),
		.op_first(op_first),
		.op_last(op_last)
	);

	// stage 2, products registered one cycle later
	mult_array mult_array_inst (
		.i(i),
		.arst_n(arst_n),
		.op_a(op_a),
		.op_b(op_b),
		.op_valid(op_valid),
		.op_first(op_first),
		.op_last(op_last),
		.prod(prod),
		.prod_valid(prod_valid),
		.prod_first(prod_first),
		.prod_last(prod_last)
	);

	// stage 3
	// acts on the tags alone, result lands two edges after en
	result_accum result_accum_inst (
		.i(i),
		.arst_n(arst_n),
		.prod(prod),
		.prod_valid(prod_valid),
		.prod_first(prod_first),
		.prod_last(prod_last),
		.result(result),
		.done(done)
	);

endmodule

/* tb/mat_mult_checker.sv */
`timescale 1ns/1ns

module mat_mult_checker import mm_pkg::*; (
	input logic i,
	input logic arst_n,
	input logic en,
	input mode_t mat_mode,
	input logic done
);

	// a matrix result never sits next to another done
	// only back-to-back element-wise items give done twice in a row
	assert property (@(posedge i) disable iff (!arst_n)
		done ##1 done |-> $past(en && mat_mode == MODE_ELEM, 3))
	else $error("done high twice in a row without element-wise items");

	// pipeline is empty when reset goes away
	assert property (@(posedge i) $rose(arst_n) |-> !done)
	else $error("done high right after reset release");

	// en sampled at edge k shows done at the sample of edge k+3
	assert property (@(posedge i) disable iff (!arst_n)
		en && mat_mode == MODE_ELEM |-> ##3 done)
	else $error("element-wise item gave no done");

endmodule

bind mat_mult mat_mult_checker mat_mult_checker_inst (
	.i(i),
	.arst_n(arst_n),
	.en(en),
	.mat_mode(mat_mode),
	.done(done)
);

/* tb/mat_mult_tb.sv */
`timescale 1ns/1ns
`include "mm_params.svh"

module mat_mult_tb import mm_pkg::*;;

	localparam int ELEM_ITEMS = 20;
	localparam int MAT_ITEMS = 10;
	localparam int GAP_ITEMS = 6;
	localparam int MAX_GAP = 3; // longest en gap between two steps
	localparam int DRAIN = 5; // idle cycles after each test
	localparam int STIM_CYCLES = 2 + 4
		+ (ELEM_ITEMS + DRAIN)
		+ (MAT_ITEMS * `MM_N + DRAIN)
		+ (GAP_ITEMS * (`MM_N + (`MM_N - 1) * MAX_GAP) + DRAIN)
		+ (2 + 4 + `MM_N + DRAIN)
		+ (`MM_N + DRAIN)
		+ DRAIN;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 20;

	logic i;
	logic arst_n;
	logic en;
	mode_t mat_mode;
	elem_mat_t a;
	elem_mat_t b;
	acc_mat_t result;
	logic done;

	logic item_ends; // this en finishes a result
	logic [2:0] done_pipe; // expected done, one bit per pipeline edge
	acc_mat_t exp_q[$];

	mat_mult mat_mult_inst (
		.i(i),
		.arst_n(arst_n),
		.en(en),
		.mat_mode(mat_mode),
		.a(a),
		.b(b),
		.result(result),
		.done(done)
	);

	initial begin
		i = 1'b0;
		forever #5 i = ~i;
	end

	// done is due two edges after the finishing en is sampled
	always @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			done_pipe <= '0;
		end else begin
			done_pipe <= {done_pipe[1:0], en && item_ends};
		end
	end

	function automatic acc_mat_t ref_result(mode_t mode, elem_mat_t ma, elem_mat_t mb);
		acc_mat_t res;
		res = '0;
		for (int r = 0; r < `MM_N; r++) begin
			for (int c = 0; c < `MM_N; c++) begin
				if (mode == MODE_ELEM) begin
					res[r][c] = acc_t'(ma[r][c]) * acc_t'(mb[r][c]);
				end else begin
					for (int s = 0; s < `MM_N; s++) begin
						res[r][c] = res[r][c] + acc_t'(ma[r][s]) * acc_t'(mb[s][c]);
					end
				end
			end
		end
		return res;
	endfunction

	function automatic elem_mat_t rand_mat();
		elem_mat_t m;
		for (int r = 0; r < `MM_N; r++) begin
			for (int c = 0; c < `MM_N; c++) begin
				m[r][c] = elem_t'($urandom);
			end
		end
		return m;
	endfunction

	task automatic check_result(acc_mat_t got, acc_mat_t exp);
		logic bad;
		int bad_r;
		int bad_c;
		bad = 1'b0;
		bad_r = 0;
		bad_c = 0;
		for (int r = 0; r < `MM_N; r++) begin
			for (int c = 0; c < `MM_N; c++) begin
				if (!bad && got[r][c] !== exp[r][c]) begin
					bad = 1'b1; // report the first wrong cell only
					bad_r = r;
					bad_c = c;
				end
			end
		end
		if (bad) begin
			$display("ERROR result[%0d][%0d] got 0x%h expected 0x%h",
				bad_r, bad_c, got[bad_r][bad_c], exp[bad_r][bad_c]);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_done(logic got, logic exp);
		if (got !== exp) begin
			if (exp) begin
				$display("done did not come when a result was due at %0t", $time);
			end else begin
				$display("done was high at %0t with no result due", $time);
			end
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic drive_cycle(logic en_v, mode_t mode_v, elem_mat_t a_v, elem_mat_t b_v,
		logic last_v);
		@(posedge i);
		#1;
		en = en_v;
		mat_mode = mode_v;
		a = a_v;
		b = b_v;
		item_ends = last_v;
	endtask

	task automatic idle_cycles(int n);
		for (int k = 0; k < n; k++) begin
			drive_cycle(1'b0, mat_mode, a, b, 1'b0);
		end
	endtask

	task automatic elem_item(elem_mat_t ma, elem_mat_t mb);
		exp_q.push_back(ref_result(MODE_ELEM, ma, mb));
		drive_cycle(1'b1, MODE_ELEM, ma, mb, 1'b1);
	endtask

	// one full step sequence with both matrices held
	task automatic mat_sequence(elem_mat_t ma, elem_mat_t mb);
		exp_q.push_back(ref_result(MODE_MAT, ma, mb));
		for (int s = 0; s < `MM_N; s++) begin
			drive_cycle(1'b1, MODE_MAT, ma, mb, s == `MM_N - 1);
		end
	endtask

	// compares every done against the schedule and the queue
	initial begin : compare_results
		acc_mat_t expected;
		forever begin
			@(negedge i);
			if (arst_n) begin
				check_done(done, done_pipe[2]);
				if (done && exp_q.size() == 0) begin
					$display("done came but no expected result was queued");
					$display("Test FAILED");
					$fatal(1);
				end else if (done) begin
					expected = exp_q.pop_front();
					check_result(result, expected);
				end
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge i);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
				$display("Test FAILED");
				$fatal(1);
			end
		end
	end

	initial begin : stimulus
		int seed_dummy;
		int gap;
		elem_mat_t ma;
		elem_mat_t mb;
		elem_t max_v;
		acc_mat_t max_exp;
		seed_dummy = $urandom(59);
		arst_n = 1'b0;
		en = 1'b0;
		mat_mode = MODE_ELEM;
		a = '0;
		b = '0;
		item_ends = 1'b0;
		repeat (2) @(posedge i);
		#1;
		arst_n = 1'b1;

		// reset state
		idle_cycles(4);
		@(negedge i);
		check_result(result, '0);

		// element-wise, back to back
		for (int n = 0; n < ELEM_ITEMS; n++) begin
			elem_item(rand_mat(), rand_mat());
		end
		idle_cycles(DRAIN);

		// matrix mode, sequences back to back
		for (int n = 0; n < MAT_ITEMS; n++) begin
			mat_sequence(rand_mat(), rand_mat());
		end
		idle_cycles(DRAIN);

		// matrix mode with en gaps between steps
		for (int n = 0; n < GAP_ITEMS; n++) begin
			ma = rand_mat();
			mb = rand_mat();
			exp_q.push_back(ref_result(MODE_MAT, ma, mb));
			for (int s = 0; s < `MM_N; s++) begin
				drive_cycle(1'b1, MODE_MAT, ma, mb, s == `MM_N - 1);
				if (s < `MM_N - 1) begin
					gap = $urandom_range(MAX_GAP, 0);
					idle_cycles(gap);
				end
			end
		end
		idle_cycles(DRAIN);

		// partial sequence abandoned by a switch to element-wise
		ma = rand_mat();
		mb = rand_mat();
		drive_cycle(1'b1, MODE_MAT, ma, mb, 1'b0);
		drive_cycle(1'b1, MODE_MAT, ma, mb, 1'b0);
		for (int n = 0; n < 4; n++) begin
			elem_item(rand_mat(), rand_mat());
		end
		mat_sequence(rand_mat(), rand_mat()); // counter must start at 0 again
		idle_cycles(DRAIN);

		// all elements at the maximum, full dot product width
		max_v = '1;
		for (int r = 0; r < `MM_N; r++) begin
			for (int c = 0; c < `MM_N; c++) begin
				ma[r][c] = max_v;
				mb[r][c] = max_v;
				max_exp[r][c] = acc_t'(`MM_N) * acc_t'(max_v) * acc_t'(max_v);
			end
		end
		exp_q.push_back(max_exp);
		for (int s = 0; s < `MM_N; s++) begin
			drive_cycle(1'b1, MODE_MAT, ma, mb, s == `MM_N - 1);
		end
		idle_cycles(DRAIN);

		idle_cycles(DRAIN);
		@(negedge i);
		if (exp_q.size() == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("%0d expected results never arrived", exp_q.size());
			$display("Test FAILED");
			$fatal(1);
		end
	end

endmodule

/* build.f */
+incdir+rtl
rtl/mm_pkg.sv
rtl/operand_sched.sv
rtl/mult_array.sv
rtl/result_accum.sv
rtl/mat_mult.sv
tb/mat_mult_checker.sv
tb/mat_mult_tb.sv

/* Bender.yml */
package:
  name: mat_mult

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mm_pkg.sv
      - rtl/operand_sched.sv
      - rtl/mult_array.sv
      - rtl/result_accum.sv
      - rtl/mat_mult.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/mat_mult_checker.sv
      - tb/mat_mult_tb.sv
